// File: design/mix_pkg.sv
package mix_pkg;

    localparam int NUM_SRC   = 4;
    localparam int FRAME_LEN = 256;
    localparam int SAMPLE_W  = 24;
    localparam int VOL_W     = 16;
    localparam int MUL_LAT   = 4;

    localparam int PHASE_W   = $clog2(FRAME_LEN);
    localparam int POP_W     = 2 * NUM_SRC;          // One pop per source and side.
    localparam int SRC_W     = $clog2(NUM_SRC);
    localparam int IDX_W     = SRC_W + 1;
    localparam int ACC_FIRST = MUL_LAT + 1;          // First product back from the scaler.
    localparam int ACC_LAST  = MUL_LAT + POP_W;

    localparam int PP_W      = SAMPLE_W + VOL_W / 2 + 1;
    localparam int PROD_W    = SAMPLE_W + VOL_W + 1;

    localparam logic signed [SAMPLE_W-1:0] SAMPLE_MAX = {1'b0, {(SAMPLE_W - 1){1'b1}}};
    localparam logic signed [SAMPLE_W-1:0] SAMPLE_MIN = {1'b1, {(SAMPLE_W - 1){1'b0}}};

    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 32;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL     = 8'h00; // Bit 0 enable.
    localparam logic [AXI_ADDR_W-1:0] ADDR_STATUS   = 8'h04; // Clip flags, W1C.
    localparam logic [AXI_ADDR_W-1:0] ADDR_FRAMES   = 8'h08; // Read only.
    localparam logic [AXI_ADDR_W-1:0] ADDR_VOL_BASE = 8'h10; // One word per source.

    typedef struct packed {
        logic [VOL_W-1:0] vol_r;
        logic [VOL_W-1:0] vol_l;
    } vol_pair_t;

    typedef union packed {
        logic [AXI_DATA_W-1:0] raw;
        vol_pair_t             pair;
    } vol_word_u;

endpackage

// File: design/mix_ctrl_if.sv
`timescale 1ns/1ps

interface mix_ctrl_if;
    import mix_pkg::*;

    vol_word_u  vol [NUM_SRC];
    logic       enable;
    logic       frame_tick; // High for one cycle at the frame end.
    logic [1:0] clip;       // Saturation event per side.

    modport regs (
        output vol,
        output enable,
        input  frame_tick,
        input  clip
    );

    modport engine (
        input  vol,
        input  enable,
        output frame_tick,
        output clip
    );

endinterface

// File: design/mix_regs.sv
`timescale 1ns/1ps

module mix_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [mix_pkg::AXI_ADDR_W-1:0] s_awaddr_i,
    input  logic                          s_awvalid_i,
    input  logic [mix_pkg::AXI_DATA_W-1:0] s_wdata_i,
    input  logic                          s_wvalid_i,
    input  logic                          s_bready_i,
    input  logic [mix_pkg::AXI_ADDR_W-1:0] s_araddr_i,
    input  logic                          s_arvalid_i,
    input  logic                          s_rready_i,
    output logic                          s_awready_o,
    output logic                          s_wready_o,
    output logic [1:0]                    s_bresp_o,
    output logic                          s_bvalid_o,
    output logic                          s_arready_o,
    output logic [mix_pkg::AXI_DATA_W-1:0] s_rdata_o,
    output logic [1:0]                    s_rresp_o,
    output logic                          s_rvalid_o,
    mix_ctrl_if.regs                      ctrl
);
    import mix_pkg::*;

    vol_word_u             vol_q [NUM_SRC];
    logic                  enable_q;
    logic [1:0]            clip_q;
    logic [AXI_DATA_W-1:0] frames_q;
    logic                  bvalid_q;
    logic [1:0]            bresp_q;
    logic                  ar_pend_q;
    logic [AXI_ADDR_W-1:0] ar_addr_q;
    logic                  rvalid_q;
    logic [1:0]            rresp_q;
    logic [AXI_DATA_W-1:0] rdata_q;
    logic                  wr_fire;
    logic                  wr_ok;
    logic [1:0]            clip_clr;
    logic                  rd_ok;
    logic [AXI_DATA_W-1:0] rd_word;

    function automatic logic vol_hit(input logic [AXI_ADDR_W-1:0] addr);
        return (addr[1:0] == 2'b00) && (addr >= ADDR_VOL_BASE) &&
               (addr < ADDR_VOL_BASE + 4 * NUM_SRC);
    endfunction

    function automatic logic [SRC_W-1:0] vol_sel(input logic [AXI_ADDR_W-1:0] addr);
        logic [AXI_ADDR_W-1:0] off;
        off = addr - ADDR_VOL_BASE;
        return off[SRC_W+1:2];
    endfunction

    // AW and W are taken together, and only while no response is pending.
    assign wr_fire     = s_awvalid_i & s_wvalid_i & ~bvalid_q;
    assign s_awready_o = wr_fire;
    assign s_wready_o  = wr_fire;
    assign s_arready_o = ~ar_pend_q & ~rvalid_q;

    assign wr_ok = (s_awaddr_i == ADDR_CTRL) || (s_awaddr_i == ADDR_STATUS) ||
                   (s_awaddr_i == ADDR_FRAMES) || vol_hit(s_awaddr_i);
    assign clip_clr = (wr_fire && s_awaddr_i == ADDR_STATUS) ? s_wdata_i[1:0] : 2'b00;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid_q <= 1'b0;
            enable_q <= 1'b0;
            clip_q   <= 2'b00;
            frames_q <= '0;
            for (int k = 0; k < NUM_SRC; k++) begin
                vol_q[k].raw <= '0;
            end
        end else begin
            if (ctrl.frame_tick) begin
                frames_q <= frames_q + 1'b1;
            end
            clip_q <= (clip_q & ~clip_clr) | ctrl.clip; // New event beats the clear.
            if (bvalid_q && s_bready_i) begin
                bvalid_q <= 1'b0;
            end
            if (wr_fire) begin
                bvalid_q <= 1'b1;
                if (s_awaddr_i == ADDR_CTRL) begin
                    enable_q <= s_wdata_i[0];
                end
                if (vol_hit(s_awaddr_i)) begin
                    vol_q[vol_sel(s_awaddr_i)].raw <= s_wdata_i;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_comb begin
        rd_ok   = 1'b1;
        rd_word = '0;
        if (ar_addr_q == ADDR_CTRL) begin
            rd_word[0] = enable_q;
        end else if (ar_addr_q == ADDR_STATUS) begin
            rd_word[1:0] = clip_q;
        end else if (ar_addr_q == ADDR_FRAMES) begin
            rd_word = frames_q;
        end else if (vol_hit(ar_addr_q)) begin
            rd_word = vol_q[vol_sel(ar_addr_q)].raw;
        end else begin
            rd_ok = 1'b0;
        end
    end

    // Address is held one cycle, data is registered the next.
    always_ff @(posedge clk) begin
        if (rst) begin
            ar_pend_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else if (ar_pend_q) begin
            ar_pend_q <= 1'b0;
            rvalid_q  <= 1'b1;
        end else begin
            if (s_arvalid_i && s_arready_o) begin
                ar_pend_q <= 1'b1;
            end
            if (rvalid_q && s_rready_i) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_arvalid_i && s_arready_o) begin
            ar_addr_q <= s_araddr_i;
        end
        if (ar_pend_q) begin
            rdata_q <= rd_word;
            rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign s_bvalid_o  = bvalid_q;
    assign s_bresp_o   = bresp_q;
    assign s_rvalid_o  = rvalid_q;
    assign s_rresp_o   = rresp_q;
    assign s_rdata_o   = rdata_q;
    assign ctrl.vol    = vol_q;
    assign ctrl.enable = enable_q;

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o));

endmodule

// File: design/vol_scaler.sv
`timescale 1ns/1ps

module vol_scaler (
    input  logic                                clk,
    input  logic signed [mix_pkg::SAMPLE_W-1:0] sample_i,
    input  logic        [mix_pkg::VOL_W-1:0]    vol_i,
    output logic signed [mix_pkg::SAMPLE_W-1:0] prod_o
);
    import mix_pkg::*;

    logic signed [SAMPLE_W-1:0] smp_q;
    logic        [VOL_W-1:0]    vol_q;
    logic signed [PP_W-1:0]     pp_lo_q;
    logic signed [PP_W-1:0]     pp_hi_q;
    logic signed [PROD_W-1:0]   sum_q;
    logic signed [PROD_W-1:0]   shifted;
    logic signed [SAMPLE_W-1:0] prod_q;

    // Floor of sample * vol / 2^16.
    assign shifted = sum_q >>> VOL_W;

    always_ff @(posedge clk) begin
        smp_q   <= sample_i;
        vol_q   <= vol_i;
        // Split the volume in bytes; each half is zero extended to stay unsigned.
        pp_lo_q <= smp_q * $signed({1'b0, vol_q[VOL_W/2-1:0]});
        pp_hi_q <= smp_q * $signed({1'b0, vol_q[VOL_W-1:VOL_W/2]});
        sum_q   <= (pp_hi_q <<< (VOL_W / 2)) + pp_lo_q;
        prod_q  <= shifted[SAMPLE_W-1:0];
    end

    assign prod_o = prod_q;

endmodule

// File: design/mix_engine.sv
`timescale 1ns/1ps

module mix_engine (
    input  logic                                        clk,
    input  logic                                        rst,
    mix_ctrl_if.engine                                  ctrl,
    output logic [mix_pkg::POP_W-1:0]                   src_pop_o,
    input  logic [mix_pkg::NUM_SRC*mix_pkg::SAMPLE_W-1:0] src_data_i,
    input  logic [1:0]                                  snk_pop_i,
    output logic [mix_pkg::SAMPLE_W-1:0]                snk_data_o,
    output logic [1:0]                                  snk_ack_o
);
    import mix_pkg::*;

    logic [PHASE_W-1:0]         phase_q;
    logic [POP_W-1:0]           pop_q;
    logic signed [SAMPLE_W-1:0] smp_mux_q;
    logic [VOL_W-1:0]           vol_mux_q;
    logic signed [SAMPLE_W-1:0] prod;
    logic signed [SAMPLE_W-1:0] acc_q [2];
    logic signed [SAMPLE_W-1:0] hold_q [2];
    logic signed [SAMPLE_W:0]   sum;
    logic [1:0]                 clip_q;
    logic [1:0]                 ack_q;
    logic                       chsel_q;
    logic                       frame_end;
    logic                       in_walk;
    logic                       acc_en;
    logic                       acc_side;
    logic [PHASE_W-1:0]         acc_off;
    logic [IDX_W-1:0]           idx;

    assign frame_end = (phase_q == FRAME_LEN - 1);
    assign in_walk   = (phase_q < POP_W);       // Sample k returns in phase k.
    assign idx       = phase_q[IDX_W-1:0];
    assign acc_en    = (phase_q >= ACC_FIRST) && (phase_q <= ACC_LAST);
    assign acc_off   = phase_q - PHASE_W'(ACC_FIRST);
    assign acc_side  = acc_off[0];              // Even slots are left.

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q <= '0;
            pop_q   <= '0;
        end else begin
            phase_q <= frame_end ? '0 : phase_q + 1'b1;
            if (phase_q == FRAME_LEN - 2) begin
                pop_q <= POP_W'(1); // Walk starts in the last cycle.
            end else begin
                pop_q <= pop_q << 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_walk && ctrl.enable) begin
            smp_mux_q <= src_data_i[idx[IDX_W-1:1]*SAMPLE_W +: SAMPLE_W];
        end else begin
            smp_mux_q <= '0;
        end
        vol_mux_q <= idx[0] ? ctrl.vol[idx[IDX_W-1:1]].pair.vol_r
                            : ctrl.vol[idx[IDX_W-1:1]].pair.vol_l;
    end

    vol_scaler vol_scaler_inst (
        .clk      (clk),
        .sample_i (smp_mux_q),
        .vol_i    (vol_mux_q),
        .prod_o   (prod)
    );

    assign sum = acc_q[acc_side] + prod;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q  <= '{default: '0};
            hold_q <= '{default: '0};
            clip_q <= 2'b00;
        end else begin
            clip_q <= 2'b00;
            if (frame_end) begin
                hold_q <= acc_q;
                acc_q  <= '{default: '0};
            end else if (acc_en) begin
                if (sum[SAMPLE_W] != sum[SAMPLE_W-1]) begin
                    acc_q[acc_side]  <= sum[SAMPLE_W] ? SAMPLE_MIN : SAMPLE_MAX;
                    clip_q[acc_side] <= 1'b1;
                end else begin
                    acc_q[acc_side] <= sum[SAMPLE_W-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q   <= 2'b00;
            chsel_q <= 1'b0;
        end else begin
            ack_q <= 2'b00;
            if (snk_pop_i[0]) begin // Left wins.
                chsel_q <= 1'b0;
                ack_q   <= 2'b01;
            end else if (snk_pop_i[1]) begin
                chsel_q <= 1'b1;
                ack_q   <= 2'b10;
            end
        end
    end

    assign src_pop_o       = pop_q;
    assign snk_data_o      = hold_q[chsel_q];
    assign snk_ack_o       = ack_q;
    assign ctrl.frame_tick = frame_end;
    assign ctrl.clip       = clip_q;

    a_pop_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(src_pop_o));

    a_ack_excl: assert property (@(posedge clk) disable iff (rst)
        snk_ack_o != 2'b11);

endmodule

// File: design/audio_mixer_top.sv
`timescale 1ns/1ps

module audio_mixer_top (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [mix_pkg::AXI_ADDR_W-1:0]              s_awaddr_i,
    input  logic                                        s_awvalid_i,
    input  logic [mix_pkg::AXI_DATA_W-1:0]              s_wdata_i,
    input  logic                                        s_wvalid_i,
    input  logic                                        s_bready_i,
    input  logic [mix_pkg::AXI_ADDR_W-1:0]              s_araddr_i,
    input  logic                                        s_arvalid_i,
    input  logic                                        s_rready_i,
    output logic                                        s_awready_o,
    output logic                                        s_wready_o,
    output logic [1:0]                                  s_bresp_o,
    output logic                                        s_bvalid_o,
    output logic                                        s_arready_o,
    output logic [mix_pkg::AXI_DATA_W-1:0]              s_rdata_o,
    output logic [1:0]                                  s_rresp_o,
    output logic                                        s_rvalid_o,
    output logic [mix_pkg::POP_W-1:0]                   src_pop_o,
    input  logic [mix_pkg::NUM_SRC*mix_pkg::SAMPLE_W-1:0] src_data_i,
    input  logic [1:0]                                  snk_pop_i,
    output logic [mix_pkg::SAMPLE_W-1:0]                snk_data_o,
    output logic [1:0]                                  snk_ack_o
);

    mix_ctrl_if ctrl_if ();

    mix_regs mix_regs_inst (
        .clk         (clk),
        .rst         (rst),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_wdata_i   (s_wdata_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_rready_i  (s_rready_i),
        .s_awready_o (s_awready_o),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .ctrl        (ctrl_if.regs)
    );

    mix_engine mix_engine_inst (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl_if.engine),
        .src_pop_o  (src_pop_o),
        .src_data_i (src_data_i),
        .snk_pop_i  (snk_pop_i),
        .snk_data_o (snk_data_o),
        .snk_ack_o  (snk_ack_o)
    );

endmodule

// File: tb/tb_audio_mixer.sv
`timescale 1ns/1ps

module tb_audio_mixer;
    import mix_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYC     = 16;
    localparam int SEED          = 98803;
    localparam int QUIET_CYC     = 20;   // Past the accumulation, safe for register access.
    localparam int TOTAL_WALKS   = 41;
    localparam int MIN_CHECKED   = 39;
    localparam int AXI_SETUP_CYC = 1000;
    localparam int WATCHDOG_CYC  = RESET_CYC + (TOTAL_WALKS + 4) * FRAME_LEN + AXI_SETUP_CYC;

    logic                          clk = 1'b0;
    logic                          rst;
    logic [AXI_ADDR_W-1:0]         s_awaddr;
    logic                          s_awvalid;
    logic [AXI_DATA_W-1:0]         s_wdata;
    logic                          s_wvalid;
    logic                          s_bready;
    logic [AXI_ADDR_W-1:0]         s_araddr;
    logic                          s_arvalid;
    logic                          s_rready;
    logic                          s_awready_o;
    logic                          s_wready_o;
    logic [1:0]                    s_bresp_o;
    logic                          s_bvalid_o;
    logic                          s_arready_o;
    logic [AXI_DATA_W-1:0]         s_rdata_o;
    logic [1:0]                    s_rresp_o;
    logic                          s_rvalid_o;
    logic [POP_W-1:0]              src_pop_o;
    logic [NUM_SRC*SAMPLE_W-1:0]   src_data;
    logic [1:0]                    snk_pop;
    logic [SAMPLE_W-1:0]           snk_data_o;
    logic [1:0]                    snk_ack_o;

    logic [NUM_SRC*AXI_DATA_W-1:0] vol_model;
    logic                          en_model;
    logic [1:0]                    clip_model;
    logic [POP_W*SAMPLE_W-1:0]     walk_smp;
    logic [SAMPLE_W-1:0]           nxt_l;
    logic [SAMPLE_W-1:0]           nxt_r;
    logic [1:0]                    nxt_clip;
    logic [SAMPLE_W-1:0]           chk_l;
    logic [SAMPLE_W-1:0]           chk_r;
    int                            smp_mode;   // 0 random, 1 full-scale positive, 2 negative.
    int                            walk_cnt;
    int                            checked_cnt;
    logic                          bp_on;
    event                          walk_start;

    always #(CLK_PERIOD / 2) clk = ~clk;

    audio_mixer_top audio_mixer_top_inst (
        .clk         (clk),
        .rst         (rst),
        .s_awaddr_i  (s_awaddr),
        .s_awvalid_i (s_awvalid),
        .s_wdata_i   (s_wdata),
        .s_wvalid_i  (s_wvalid),
        .s_bready_i  (s_bready),
        .s_araddr_i  (s_araddr),
        .s_arvalid_i (s_arvalid),
        .s_rready_i  (s_rready),
        .s_awready_o (s_awready_o),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .src_pop_o   (src_pop_o),
        .src_data_i  (src_data),
        .snk_pop_i   (snk_pop),
        .snk_data_o  (snk_data_o),
        .snk_ack_o   (snk_ack_o)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Floor scaling per sample, then a saturating sum per side in pop order.
    function automatic void mix_ref(input logic [POP_W*SAMPLE_W-1:0] smps,
                                    input logic [NUM_SRC*AXI_DATA_W-1:0] vols,
                                    input logic en,
                                    output logic [SAMPLE_W-1:0] left,
                                    output logic [SAMPLE_W-1:0] right,
                                    output logic [1:0] clip);
        longint acc [2];
        longint smp;
        longint vol;
        longint lim_hi;
        longint lim_lo;
        int     side;
        lim_hi = (longint'(1) << (SAMPLE_W - 1)) - 1;
        lim_lo = -(longint'(1) << (SAMPLE_W - 1));
        acc[0] = 0;
        acc[1] = 0;
        clip   = 2'b00;
        for (int j = 0; j < POP_W; j++) begin
            side = j % 2;
            smp  = en ? longint'($signed(smps[j*SAMPLE_W +: SAMPLE_W])) : 0;
            vol  = longint'(vols[(j / 2) * AXI_DATA_W + side * VOL_W +: VOL_W]);
            acc[side] = acc[side] + ((smp * vol) >>> VOL_W);
            if (acc[side] > lim_hi) begin
                acc[side]  = lim_hi;
                clip[side] = 1'b1;
            end else if (acc[side] < lim_lo) begin
                acc[side]  = lim_lo;
                clip[side] = 1'b1;
            end
        end
        left  = SAMPLE_W'(acc[0]);
        right = SAMPLE_W'(acc[1]);
    endfunction

    function automatic logic [SAMPLE_W-1:0] gen_sample();
        case (smp_mode)
            1:       return SAMPLE_MAX;
            2:       return SAMPLE_MIN;
            default: return SAMPLE_W'($urandom);
        endcase
    endfunction

    // The latched result belongs to the previous walk.
    task automatic start_walk();
        chk_l = nxt_l;
        chk_r = nxt_r;
        for (int j = 0; j < POP_W; j++) begin
            walk_smp[j*SAMPLE_W +: SAMPLE_W] = gen_sample();
        end
        mix_ref(walk_smp, vol_model, en_model, nxt_l, nxt_r, nxt_clip);
        clip_model = clip_model | nxt_clip;
        walk_cnt++;
        -> walk_start;
    endtask

    // Source model answers each pop one cycle later.
    always @(posedge clk) begin
        if (!rst) begin
            for (int j = 0; j < POP_W; j++) begin
                if (src_pop_o[j]) begin
                    if (j == 0) begin
                        start_walk();
                    end
                    src_data[(j / 2) * SAMPLE_W +: SAMPLE_W] <= walk_smp[j*SAMPLE_W +: SAMPLE_W];
                end
            end
        end
    end

    task automatic pop_sink(input int side, output logic [SAMPLE_W-1:0] data);
        logic [1:0] sel;
        sel = (side == 0) ? 2'b01 : 2'b10;
        @(posedge clk);
        snk_pop <= sel;
        @(posedge clk);
        snk_pop <= 2'b00;
        @(posedge clk);
        if (snk_ack_o !== sel) begin
            stop_on_error($sformatf("Sink gave no acknowledge one cycle after pop %0d", side));
        end else begin
            data = snk_data_o;
        end
    endtask

    initial begin : sink_checker
        logic [SAMPLE_W-1:0] got;
        forever begin
            @(walk_start);
            pop_sink(0, got);
            check_value("snk_data_o left", got, chk_l);
            pop_sink(1, got);
            check_value("snk_data_o right", got, chk_r);
            checked_cnt++;
        end
    end

    task automatic write_reg(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        int   hold;
        logic done;
        hold = bp_on ? $urandom_range(4, 1) : 0;
        @(posedge clk);
        s_awaddr  <= addr;
        s_awvalid <= 1'b1;
        s_wdata   <= data;
        s_wvalid  <= 1'b1;
        s_bready  <= (hold == 0);
        @(posedge clk);
        while (!s_awready_o) @(posedge clk);
        check_value("s_wready_o", s_wready_o, 32'h1); // W goes with AW.
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (s_bvalid_o && s_bready) begin
                done = 1'b1;
            end else if (s_bvalid_o) begin
                if (hold <= 1) s_bready <= 1'b1; // Random B back-pressure.
                hold = hold - 1;
            end
        end
        check_value($sformatf("s_bresp_o at 0x%h", addr), s_bresp_o, exp_resp);
        s_bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int   hold;
        logic done;
        hold = bp_on ? $urandom_range(4, 1) : 0;
        @(posedge clk);
        s_araddr  <= addr;
        s_arvalid <= 1'b1;
        s_rready  <= (hold == 0);
        @(posedge clk);
        while (!s_arready_o) @(posedge clk);
        s_arvalid <= 1'b0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (s_rvalid_o && s_rready) begin
                done = 1'b1;
            end else if (s_rvalid_o) begin
                if (hold <= 1) s_rready <= 1'b1;
                hold = hold - 1;
            end
        end
        data = s_rdata_o;
        resp = s_rresp_o;
        s_rready <= 1'b0;
    endtask

    task automatic expect_reg(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] exp_data);
        logic [31:0] data;
        logic [1:0]  resp;
        read_reg(addr, data, resp);
        check_value($sformatf("s_rresp_o at 0x%h", addr), resp, RESP_OKAY);
        check_value($sformatf("s_rdata_o at 0x%h", addr), data, exp_data);
    endtask

    task automatic write_vols(input logic full);
        logic [31:0] vol;
        for (int k = 0; k < NUM_SRC; k++) begin
            vol = full ? 32'hFFFF_FFFF : $urandom;
            write_reg(ADDR_VOL_BASE + AXI_ADDR_W'(4 * k), vol, RESP_OKAY);
            vol_model[k*AXI_DATA_W +: AXI_DATA_W] = vol;
        end
    endtask

    // Lands in the quiet part of the frame after the requested walk.
    task automatic wait_walks(input int n);
        int target;
        target = walk_cnt + n;
        wait (walk_cnt >= target);
        repeat (QUIET_CYC) @(posedge clk);
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYC) @(posedge clk);
        stop_on_error("Simulation timed out before all tests finished");
    end

    initial begin : main_seq
        logic [31:0] data;
        logic [31:0] f0;
        logic [1:0]  resp;
        int          w0;
        void'($urandom(SEED));
        rst         = 1'b1;
        s_awaddr    = '0;
        s_awvalid   = 1'b0;
        s_wdata     = '0;
        s_wvalid    = 1'b0;
        s_bready    = 1'b0;
        s_araddr    = '0;
        s_arvalid   = 1'b0;
        s_rready    = 1'b0;
        src_data    = '0;
        snk_pop     = 2'b00;
        vol_model   = '0;
        en_model    = 1'b0;
        clip_model  = 2'b00;
        walk_smp    = '0;
        nxt_l       = '0;
        nxt_r       = '0;
        nxt_clip    = 2'b00;
        smp_mode    = 0;
        walk_cnt    = 0;
        checked_cnt = 0;
        bp_on       = 1'b0;
        repeat (RESET_CYC) @(posedge clk);
        rst <= 1'b0;

        wait_walks(2);
        expect_reg(ADDR_STATUS, 32'h0);
        expect_reg(ADDR_CTRL, 32'h0);

        write_vols(1'b0);
        wait_walks(1); // One walk with volumes set and the mixer still disabled.
        write_reg(ADDR_CTRL, 32'h1, RESP_OKAY);
        en_model = 1'b1;
        wait_walks(21);

        write_vols(1'b1);
        smp_mode = 1;
        wait_walks(2);
        expect_reg(ADDR_STATUS, 32'h3);
        write_reg(ADDR_STATUS, 32'h1, RESP_OKAY);
        clip_model[0] = 1'b0;
        expect_reg(ADDR_STATUS, 32'h2);
        write_reg(ADDR_STATUS, 32'h2, RESP_OKAY);
        clip_model[1] = 1'b0;
        expect_reg(ADDR_STATUS, 32'h0);
        smp_mode = 2;
        wait_walks(2);
        expect_reg(ADDR_STATUS, 32'h3);
        write_reg(ADDR_STATUS, 32'h3, RESP_OKAY);
        clip_model = 2'b00;
        expect_reg(ADDR_STATUS, 32'h0);
        smp_mode = 0;
        write_vols(1'b0);

        read_reg(ADDR_FRAMES, f0, resp);
        w0 = walk_cnt;
        wait_walks(3);
        read_reg(ADDR_FRAMES, data, resp);
        check_value("frame count delta", data - f0, walk_cnt - w0);
        for (int k = 0; k < NUM_SRC; k++) begin
            expect_reg(ADDR_VOL_BASE + AXI_ADDR_W'(4 * k), vol_model[k*AXI_DATA_W +: AXI_DATA_W]);
        end
        read_reg(8'h0C, data, resp);
        check_value("s_rresp_o at 0x0c", resp, RESP_SLVERR);
        write_reg(8'h12, 32'hDEAD_BEEF, RESP_SLVERR); // Misaligned inside the volume range.
        write_reg(8'h20, 32'hDEAD_BEEF, RESP_SLVERR);
        expect_reg(ADDR_VOL_BASE, vol_model[AXI_DATA_W-1:0]);
        expect_reg(ADDR_VOL_BASE + 8'h4, vol_model[2*AXI_DATA_W-1:AXI_DATA_W]);
        expect_reg(ADDR_CTRL, 32'h1);

        bp_on = 1'b1;
        write_vols(1'b0);
        for (int i = 0; i < 6; i++) begin
            wait_walks(1);
            expect_reg(ADDR_STATUS, {30'b0, clip_model});
            expect_reg(ADDR_VOL_BASE + AXI_ADDR_W'(4 * (i % NUM_SRC)),
                       vol_model[(i % NUM_SRC)*AXI_DATA_W +: AXI_DATA_W]);
            expect_reg(ADDR_CTRL, 32'h1);
        end
        bp_on = 1'b0;
        wait_walks(2);

        if (checked_cnt < MIN_CHECKED) begin
            stop_on_error($sformatf("Only %0d frames reached the sink check", checked_cnt));
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: vlog.f
design/mix_pkg.sv
design/mix_ctrl_if.sv
design/mix_regs.sv
design/vol_scaler.sv
design/mix_engine.sv
design/audio_mixer_top.sv
tb/tb_audio_mixer.sv

// File: Bender.yml
package:
  name: audio_mixer

sources:
  - files:
      - design/mix_pkg.sv
      - design/mix_ctrl_if.sv
      - design/mix_regs.sv
      - design/vol_scaler.sv
      - design/mix_engine.sv
      - design/audio_mixer_top.sv
  - target: test
    files:
      - tb/tb_audio_mixer.sv
